// ==== verilog/heapPkg.sv ====
// Array heap sizes and derived counts
// Command action codes and response error codes

package heapPkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int ADDRESS_BITS = 2;                  // Width of an array handle
  localparam int INDEX_BITS   = 3;                  // Width of an element index
  localparam int DATA_BITS    = 12;                 // Width of one element
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;  // Arrays in the heap
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;    // Elements per array
  localparam int QUEUE_DEPTH  = 2;                  // Command slots and host credits at reset

  // --------------------
  // Action codes
  // --------------------
  localparam int ACTION_BITS = 4;

  localparam logic [ACTION_BITS-1:0] ACT_ALLOC = 4'd1;   // Hand out an array
  localparam logic [ACTION_BITS-1:0] ACT_FREE  = 4'd2;   // Return an array for reuse
  localparam logic [ACTION_BITS-1:0] ACT_WRITE = 4'd3;   // Store an element
  localparam logic [ACTION_BITS-1:0] ACT_READ  = 4'd4;   // Fetch an element
  localparam logic [ACTION_BITS-1:0] ACT_SIZE  = 4'd5;   // Current array size
  localparam logic [ACTION_BITS-1:0] ACT_PUSH  = 4'd6;   // Append at the top
  localparam logic [ACTION_BITS-1:0] ACT_POP   = 4'd7;   // Remove from the top
  localparam logic [ACTION_BITS-1:0] ACT_ADD   = 4'd8;   // Element plus operand
  localparam logic [ACTION_BITS-1:0] ACT_SUB   = 4'd9;   // Element minus operand
  localparam logic [ACTION_BITS-1:0] ACT_OR    = 4'd10;  // Bitwise or into element
  localparam logic [ACTION_BITS-1:0] ACT_XOR   = 4'd11;  // Bitwise xor into element
  localparam logic [ACTION_BITS-1:0] ACT_AND   = 4'd12;  // Bitwise and into element

  // --------------------
  // Error codes
  // --------------------
  localparam int ERROR_BITS = 3;

  localparam logic [ERROR_BITS-1:0] ERR_NONE          = 3'd0;  // Command completed
  localparam logic [ERROR_BITS-1:0] ERR_NOT_ALLOCATED = 3'd1;  // Array never handed out or freed
  localparam logic [ERROR_BITS-1:0] ERR_OUT_OF_BOUNDS = 3'd2;  // Index at or above size
  localparam logic [ERROR_BITS-1:0] ERR_FULL          = 3'd3;  // Push onto a full array
  localparam logic [ERROR_BITS-1:0] ERR_EMPTY         = 3'd4;  // Pop from an empty array
  localparam logic [ERROR_BITS-1:0] ERR_OUT_OF_MEMORY = 3'd5;  // No array left to hand out

endpackage

// ==== verilog/commandQueue.sv ====
// Credited command buffer
// Circular queue that issues its head every cycle it holds a command
`timescale 1ns/100ps

module commandQueue
  import heapPkg::*;
(
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    cmdValid,      // Host spends a credit
  input  logic [ACTION_BITS-1:0]  cmdAction,
  input  logic [ADDRESS_BITS-1:0] cmdArray,
  input  logic [INDEX_BITS-1:0]   cmdIndex,
  input  logic [DATA_BITS-1:0]    cmdData,
  output logic                    creditReturn,  // One pulse per issued command
  output logic                    issueValid,
  output logic [ACTION_BITS-1:0]  issueAction,
  output logic [ADDRESS_BITS-1:0] issueArray,
  output logic [INDEX_BITS-1:0]   issueIndex,
  output logic [DATA_BITS-1:0]    issueData
);

  logic [ACTION_BITS-1:0]           actionSlot [QUEUE_DEPTH];  // Queued command fields
  logic [ADDRESS_BITS-1:0]          arraySlot  [QUEUE_DEPTH];
  logic [INDEX_BITS-1:0]            indexSlot  [QUEUE_DEPTH];
  logic [DATA_BITS-1:0]             dataSlot   [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]   writePointer;              // Next free slot
  logic [$clog2(QUEUE_DEPTH)-1:0]   readPointer;               // Head of queue
  logic [$clog2(QUEUE_DEPTH+1)-1:0] count;                     // Occupied slots

  assign issueValid   = count != '0;
  assign creditReturn = issueValid;             // Execute stage never stalls
  assign issueAction  = actionSlot[readPointer];
  assign issueArray   = arraySlot[readPointer];
  assign issueIndex   = indexSlot[readPointer];
  assign issueData    = dataSlot[readPointer];

  always_ff @(posedge clock) begin
    if (cmdValid) begin                         // Credits guarantee a free slot
      actionSlot[writePointer] <= cmdAction;
      arraySlot[writePointer]  <= cmdArray;
      indexSlot[writePointer]  <= cmdIndex;
      dataSlot[writePointer]   <= cmdData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      writePointer <= '0;
      readPointer  <= '0;
      count        <= '0;
    end else begin
      if (cmdValid) begin
        writePointer <= writePointer + 1'b1;    // Depth is a power of two
      end
      if (issueValid) begin
        readPointer <= readPointer + 1'b1;
      end
      case ({cmdValid, issueValid})
        2'b10:   count <= count + 1'b1;         // Accept only
        2'b01:   count <= count - 1'b1;         // Issue only
        default: count <= count;                // Both or neither
      endcase
    end
  end

endmodule

// ==== verilog/heapAllocator.sv ====
// Array allocator
// Allocation bits, LIFO stack of freed handles and the access check
`timescale 1ns/100ps

module heapAllocator
  import heapPkg::*;
(
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    issueValid,
  input  logic [ACTION_BITS-1:0]  issueAction,
  input  logic [ADDRESS_BITS-1:0] issueArray,
  output logic [ADDRESS_BITS-1:0] allocHandle,   // Handle the next Alloc receives
  output logic                    memoryFull,    // Nothing left to hand out
  output logic                    accessFault    // Addressed array not live
);

  logic [ARRAYS-1:0]       allocated;                // One bit per array
  logic [ADDRESS_BITS-1:0] freedStack [ARRAYS];      // Freed handles in free order
  logic [ADDRESS_BITS:0]   freedTop;                 // Handles on the stack
  logic [ADDRESS_BITS:0]   handedOut;                // Fresh handles used so far
  logic [ADDRESS_BITS-1:0] topSlot;                  // Slot of the newest freed handle
  logic                    freedAvailable;
  logic                    doAlloc;
  logic                    doFree;

  // --------------------
  // Next handle and checks
  // --------------------
  assign freedAvailable = freedTop != '0;
  assign topSlot        = freedTop[ADDRESS_BITS-1:0] - 1'b1;  // Wraps correctly at ARRAYS

  // Reuse freed arrays before fresh ones
  assign allocHandle = freedAvailable ? freedStack[topSlot] : handedOut[ADDRESS_BITS-1:0];

  // Top bit of handedOut means every fresh handle is gone
  assign memoryFull  = !freedAvailable && handedOut[ADDRESS_BITS];
  assign accessFault = !allocated[issueArray];      // Covers freed and never allocated

  assign doAlloc = issueValid && (issueAction == ACT_ALLOC) && !memoryFull;
  assign doFree  = issueValid && (issueAction == ACT_FREE) && !accessFault;

  // --------------------
  // State update
  // --------------------
  always_ff @(posedge clock) begin
    if (doFree) begin
      freedStack[freedTop[ADDRESS_BITS-1:0]] <= issueArray;  // Push freed handle
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freedTop  <= '0;
      handedOut <= '0;                              // First Alloc gets handle 0
    end else if (doAlloc) begin
      allocated[allocHandle] <= 1'b1;
      if (freedAvailable) begin
        freedTop <= freedTop - 1'b1;                // Pop freed stack
      end else begin
        handedOut <= handedOut + 1'b1;              // Take a fresh handle
      end
    end else if (doFree) begin
      allocated[issueArray] <= 1'b0;
      freedTop              <= freedTop + 1'b1;
    end
  end

endmodule

// ==== verilog/arrayStore.sv ====
// Element memory and per-array sizes
// Command execution with element operations and the registered response
`timescale 1ns/100ps

module arrayStore
  import heapPkg::*;
(
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    issueValid,
  input  logic [ACTION_BITS-1:0]  issueAction,
  input  logic [ADDRESS_BITS-1:0] issueArray,
  input  logic [INDEX_BITS-1:0]   issueIndex,
  input  logic [DATA_BITS-1:0]    issueData,
  input  logic [ADDRESS_BITS-1:0] allocHandle,   // From allocator
  input  logic                    memoryFull,
  input  logic                    accessFault,
  output logic                    respValid,     // One cycle after issue
  output logic [DATA_BITS-1:0]    respData,
  output logic [ERROR_BITS-1:0]   respError
);

  logic [DATA_BITS-1:0]    memory [ARRAYS][ARRAY_LENGTH];  // Fixed block per array
  logic [INDEX_BITS:0]     sizes  [ARRAYS];                // 0 to ARRAY_LENGTH
  logic [INDEX_BITS:0]     currentSize;                    // Size of addressed array
  logic [INDEX_BITS-1:0]   topIndex;                       // Last live element
  logic [DATA_BITS-1:0]    element;                        // Addressed element
  logic [DATA_BITS-1:0]    combined;                       // Element operation result
  logic                    inBounds;
  logic                    writeEnable;
  logic [INDEX_BITS-1:0]   writeIndex;
  logic [DATA_BITS-1:0]    writeValue;
  logic                    sizeEnable;
  logic [ADDRESS_BITS-1:0] sizeArray;                      // Alloc targets another array
  logic [INDEX_BITS:0]     sizeValue;
  logic [DATA_BITS-1:0]    nextData;
  logic [ERROR_BITS-1:0]   nextError;

  assign currentSize = sizes[issueArray];
  assign topIndex    = currentSize[INDEX_BITS-1:0] - 1'b1;
  assign element     = memory[issueArray][issueIndex];
  assign inBounds    = {1'b0, issueIndex} < currentSize;

  always_comb begin
    case (issueAction)
      ACT_ADD: combined = element + issueData;   // Wraps in DATA_BITS
      ACT_SUB: combined = element - issueData;
      ACT_OR:  combined = element | issueData;
      ACT_XOR: combined = element ^ issueData;
      default: combined = element & issueData;
    endcase
  end

  // --------------------
  // Command decode
  // --------------------
  always_comb begin
    writeEnable = 1'b0;
    writeIndex  = issueIndex;
    writeValue  = issueData;
    sizeEnable  = 1'b0;
    sizeArray   = issueArray;
    sizeValue   = currentSize;
    nextData    = '0;                            // Zero on any error
    nextError   = ERR_NONE;
    if (accessFault && (issueAction != ACT_ALLOC)) begin
      nextError = ERR_NOT_ALLOCATED;             // Includes a second Free
    end else begin
      case (issueAction)
        ACT_ALLOC: begin
          if (memoryFull) begin
            nextError = ERR_OUT_OF_MEMORY;
          end else begin
            sizeEnable = 1'b1;                   // New array starts empty
            sizeArray  = allocHandle;
            sizeValue  = '0;
            nextData   = DATA_BITS'(allocHandle);
          end
        end
        ACT_WRITE: begin
          writeEnable = 1'b1;
          nextData    = issueData;
          if (!inBounds) begin
            sizeEnable = 1'b1;                   // Grow to cover the index
            sizeValue  = {1'b0, issueIndex} + 1'b1;
          end
        end
        ACT_READ: begin
          if (inBounds) begin
            nextData = element;
          end else begin
            nextError = ERR_OUT_OF_BOUNDS;
          end
        end
        ACT_ADD, ACT_SUB, ACT_OR, ACT_XOR, ACT_AND: begin
          if (inBounds) begin
            writeEnable = 1'b1;
            writeValue  = combined;
            nextData    = combined;              // New value returned
          end else begin
            nextError = ERR_OUT_OF_BOUNDS;
          end
        end
        ACT_SIZE: begin
          nextData = DATA_BITS'(currentSize);
        end
        ACT_PUSH: begin
          if (currentSize[INDEX_BITS]) begin     // Size equals ARRAY_LENGTH
            nextError = ERR_FULL;
          end else begin
            writeEnable = 1'b1;
            writeIndex  = currentSize[INDEX_BITS-1:0];
            sizeEnable  = 1'b1;
            sizeValue   = currentSize + 1'b1;
            nextData    = issueData;
          end
        end
        ACT_POP: begin
          if (currentSize == '0) begin
            nextError = ERR_EMPTY;
          end else begin
            sizeEnable = 1'b1;
            sizeValue  = currentSize - 1'b1;
            nextData   = memory[issueArray][topIndex];
          end
        end
        default: begin
          nextData = '0;                         // Free and unused codes touch nothing here
        end
      endcase
    end
  end

  // --------------------
  // Storage and response
  // --------------------
  always_ff @(posedge clock) begin
    if (issueValid && writeEnable) begin
      memory[issueArray][writeIndex] <= writeValue;
    end
    respData  <= nextData;
    respError <= nextError;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
      for (int i = 0; i < ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      respValid <= issueValid;                   // Exactly one response per issue
      if (issueValid && sizeEnable) begin
        sizes[sizeArray] <= sizeValue;
      end
    end
  end

endmodule

// ==== verilog/arrayHeap.sv ====
// Array heap top level
// Command queue feeding the allocator and the array store
`timescale 1ns/100ps

module arrayHeap
  import heapPkg::*;
(
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    cmdValid,
  input  logic [ACTION_BITS-1:0]  cmdAction,
  input  logic [ADDRESS_BITS-1:0] cmdArray,
  input  logic [INDEX_BITS-1:0]   cmdIndex,
  input  logic [DATA_BITS-1:0]    cmdData,
  output logic                    creditReturn,
  output logic                    respValid,
  output logic [DATA_BITS-1:0]    respData,
  output logic [ERROR_BITS-1:0]   respError
);

  // --------------------
  // Issue stage wires
  // --------------------
  logic                    issueValid;
  logic [ACTION_BITS-1:0]  issueAction;
  logic [ADDRESS_BITS-1:0] issueArray;
  logic [INDEX_BITS-1:0]   issueIndex;
  logic [DATA_BITS-1:0]    issueData;
  logic [ADDRESS_BITS-1:0] allocHandle;   // Allocator results for this issue
  logic                    memoryFull;
  logic                    accessFault;

  commandQueue commandQueue_inst (
    .clock        (clock),
    .resetN       (resetN),
    .cmdValid     (cmdValid),
    .cmdAction    (cmdAction),
    .cmdArray     (cmdArray),
    .cmdIndex     (cmdIndex),
    .cmdData      (cmdData),
    .creditReturn (creditReturn),
    .issueValid   (issueValid),
    .issueAction  (issueAction),
    .issueArray   (issueArray),
    .issueIndex   (issueIndex),
    .issueData    (issueData)
  );

  heapAllocator heapAllocator_inst (
    .clock       (clock),
    .resetN      (resetN),
    .issueValid  (issueValid),
    .issueAction (issueAction),
    .issueArray  (issueArray),
    .allocHandle (allocHandle),
    .memoryFull  (memoryFull),
    .accessFault (accessFault)
  );

  arrayStore arrayStore_inst (
    .clock       (clock),
    .resetN      (resetN),
    .issueValid  (issueValid),
    .issueAction (issueAction),
    .issueArray  (issueArray),
    .issueIndex  (issueIndex),
    .issueData   (issueData),
    .allocHandle (allocHandle),
    .memoryFull  (memoryFull),
    .accessFault (accessFault),
    .respValid   (respValid),
    .respData    (respData),
    .respError   (respError)
  );

endmodule

// ==== verification/arrayHeapTb.sv ====
// Array heap testbench with a random credited command stream
// Reference model of allocator, sizes and memory with in-order response checks
`timescale 1ns/100ps

module arrayHeapTb
  import heapPkg::*;
  ();

  logic                    clock;
  logic                    resetN;
  logic                    cmdValid;
  logic [ACTION_BITS-1:0]  cmdAction;
  logic [ADDRESS_BITS-1:0] cmdArray;
  logic [INDEX_BITS-1:0]   cmdIndex;
  logic [DATA_BITS-1:0]    cmdData;
  logic                    creditReturn;
  logic                    respValid;
  logic [DATA_BITS-1:0]    respData;
  logic [ERROR_BITS-1:0]   respError;

  int commandCount = 2000;                          // Directed plus random commands
  int seed;
  int commandsSent;
  int creditsReturned;                              // creditReturn pulses seen
  int responseCount;
  int responseErrors;
  int protocolErrors;

  bit                      modelAllocated [ARRAYS];
  logic [ADDRESS_BITS-1:0] modelFreed [$];          // Freed handles, newest at back
  int                      modelHandedOut;
  int                      modelSize [ARRAYS];
  logic [DATA_BITS-1:0]    modelMem [ARRAYS][ARRAY_LENGTH];
  bit                      modelKnown [ARRAYS][ARRAY_LENGTH];  // Element written at least once

  logic [DATA_BITS-1:0]    expData [$];             // Expected responses in command order
  logic [ERROR_BITS-1:0]   expError [$];
  bit                      expKnown [$];

  arrayHeap arrayHeap_inst (
    .clock        (clock),
    .resetN       (resetN),
    .cmdValid     (cmdValid),
    .cmdAction    (cmdAction),
    .cmdArray     (cmdArray),
    .cmdIndex     (cmdIndex),
    .cmdData      (cmdData),
    .creditReturn (creditReturn),
    .respValid    (respValid),
    .respData     (respData),
    .respError    (respError)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;                         // 10 ns period

  // --------------------
  // Reference model
  // --------------------
  function automatic void modelCommand(input logic [ACTION_BITS-1:0] action,
                                       input logic [ADDRESS_BITS-1:0] arr,
                                       input logic [INDEX_BITS-1:0] idx,
                                       input logic [DATA_BITS-1:0] data);
    logic [DATA_BITS-1:0]    value;
    logic [ERROR_BITS-1:0]   err;
    logic [ADDRESS_BITS-1:0] handle;
    bit                      known;
    int                      size;
    int                      i;
    value  = '0;                                    // Zero data on any error
    err    = ERR_NONE;
    handle = '0;
    known  = 1'b1;
    size   = modelSize[arr];
    i      = int'(idx);
    if (action != ACT_ALLOC && !modelAllocated[arr]) begin
      err = ERR_NOT_ALLOCATED;                      // Freed, never allocated or double free
    end else begin
      case (action)
        ACT_ALLOC: begin
          if (modelFreed.size() > 0) begin
            handle = modelFreed.pop_back();         // Last freed comes back first
          end else if (modelHandedOut < ARRAYS) begin
            handle = ADDRESS_BITS'(modelHandedOut);
            modelHandedOut++;
          end else begin
            err = ERR_OUT_OF_MEMORY;
          end
          if (err == ERR_NONE) begin
            modelAllocated[handle] = 1'b1;
            modelSize[handle]      = 0;
            value                  = DATA_BITS'(handle);
          end
        end
        ACT_FREE: begin
          modelAllocated[arr] = 1'b0;
          modelFreed.push_back(arr);
        end
        ACT_WRITE: begin
          modelMem[arr][i]   = data;
          modelKnown[arr][i] = 1'b1;
          if (size < i + 1) modelSize[arr] = i + 1;  // Grows to cover index
          value = data;
        end
        ACT_READ: begin
          if (i < size) begin
            value = modelMem[arr][i];
            known = modelKnown[arr][i];
          end else begin
            err = ERR_OUT_OF_BOUNDS;
          end
        end
        ACT_SIZE: value = DATA_BITS'(size);
        ACT_PUSH: begin
          if (size == ARRAY_LENGTH) begin
            err = ERR_FULL;
          end else begin
            modelMem[arr][size]   = data;
            modelKnown[arr][size] = 1'b1;
            modelSize[arr]        = size + 1;
            value                 = data;
          end
        end
        ACT_POP: begin
          if (size == 0) begin
            err = ERR_EMPTY;
          end else begin
            value          = modelMem[arr][size - 1];
            known          = modelKnown[arr][size - 1];
            modelSize[arr] = size - 1;
          end
        end
        default: begin                              // Read-modify-write operations
          if (i >= size) begin
            err = ERR_OUT_OF_BOUNDS;
          end else begin
            case (action)
              ACT_ADD: value = modelMem[arr][i] + data;  // Wraps at 12 bits
              ACT_SUB: value = modelMem[arr][i] - data;
              ACT_OR:  value = modelMem[arr][i] | data;
              ACT_XOR: value = modelMem[arr][i] ^ data;
              default: value = modelMem[arr][i] & data;
            endcase
            known            = modelKnown[arr][i];
            modelMem[arr][i] = value;
          end
        end
      endcase
    end
    expData.push_back(value);
    expError.push_back(err);
    expKnown.push_back(known);
  endfunction

  // --------------------
  // Host side stimulus
  // --------------------
  task automatic sendCommand(input logic [ACTION_BITS-1:0] action,
                             input logic [ADDRESS_BITS-1:0] arr,
                             input logic [INDEX_BITS-1:0] idx,
                             input logic [DATA_BITS-1:0] data);
    @(negedge clock);
    cmdValid = 1'b0;
    while (QUEUE_DEPTH + creditsReturned - commandsSent <= 0) begin
      @(negedge clock);                             // Hold until a credit comes back
    end
    cmdValid  = 1'b1;
    cmdAction = action;
    cmdArray  = arr;
    cmdIndex  = idx;
    cmdData   = data;
    modelCommand(action, arr, idx, data);
    commandsSent++;
  endtask

  task automatic idleCycle();
    @(negedge clock);
    cmdValid = 1'b0;
  endtask

  task automatic sendRandomCommand();
    int                     pick;
    logic [ACTION_BITS-1:0] action;
    pick = $unsigned($random(seed)) % 21;
    case (pick)                                     // Weighted toward Write, Push, Read, Alloc
      0, 1, 2, 3: action = ACT_WRITE;
      4, 5, 6:    action = ACT_PUSH;
      7, 8, 9:    action = ACT_READ;
      10, 11:     action = ACT_ALLOC;
      12:         action = ACT_FREE;
      13, 14:     action = ACT_POP;
      15:         action = ACT_SIZE;
      16:         action = ACT_ADD;
      17:         action = ACT_SUB;
      18:         action = ACT_OR;
      19:         action = ACT_XOR;
      default:    action = ACT_AND;
    endcase
    sendCommand(action, ADDRESS_BITS'($random(seed)), INDEX_BITS'($random(seed)),
                DATA_BITS'($random(seed)));
  endtask

  // --------------------
  // Credit and response monitor
  // --------------------
  always @(posedge clock) begin : monitor
    logic [DATA_BITS-1:0]  expectedData;
    logic [ERROR_BITS-1:0] expectedError;
    bit                    expectedKnown;
    if (creditReturn) begin
      assert (creditsReturned < commandsSent) else begin
        protocolErrors++;
        $display("Error %0d ns: credit returned with no command outstanding", $time);
      end
      creditsReturned++;
    end
    if (respValid) begin
      assert (expError.size() != 0) else begin
        protocolErrors++;
        $display("Error %0d ns: response with no command outstanding", $time);
      end
      if (expError.size() != 0) begin
        expectedData  = expData.pop_front();
        expectedError = expError.pop_front();
        expectedKnown = expKnown.pop_front();
        assert (respError === expectedError && (!expectedKnown || respData === expectedData))
        else begin
          responseErrors++;
          $display("Error %0d ns: response %0d data %h error %0d, expected data %h error %0d",
                   $time, responseCount, respData, respError, expectedData, expectedError);
        end
        responseCount++;
      end
    end
  end

  initial begin : stimulus
    seed      = 37336;
    resetN    = 1'b0;
    cmdValid  = 1'b0;
    cmdAction = ACT_SIZE;
    cmdArray  = '0;
    cmdIndex  = '0;
    cmdData   = '0;
    for (int a = 0; a < ARRAYS; a++) begin
      modelAllocated[a] = 1'b0;
      modelSize[a]      = 0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    sendCommand(ACT_WRITE, 2'd2, 3'd1, 12'h5a5);    // Never allocated arrays
    sendCommand(ACT_FREE, 2'd0, '0, '0);
    repeat (5) sendCommand(ACT_ALLOC, '0, '0, '0);  // Handles 0 to 3, then out of memory
    sendCommand(ACT_FREE, 2'd1, '0, '0);
    sendCommand(ACT_FREE, 2'd3, '0, '0);
    sendCommand(ACT_FREE, 2'd3, '0, '0);            // Double free
    sendCommand(ACT_ALLOC, '0, '0, '0);             // Expect 3 then 1
    sendCommand(ACT_ALLOC, '0, '0, '0);
    sendCommand(ACT_POP, 2'd0, '0, '0);
    sendCommand(ACT_READ, 2'd0, 3'd4, '0);
    while (commandsSent < commandCount) begin
      if ($unsigned($random(seed)) % 4 == 0) idleCycle();
      else sendRandomCommand();
    end
    idleCycle();
    while (expError.size() != 0) @(negedge clock);  // Drain outstanding responses
    repeat (3) @(negedge clock);
    assert (creditsReturned == commandsSent && responseCount == commandsSent) else begin
      protocolErrors++;
      $display("Error %0d ns: %0d credits and %0d responses for %0d commands",
               $time, creditsReturned, responseCount, commandsSent);
    end
    $display("Finished %0d commands: %0d response errors, %0d protocol errors",
             commandsSent, responseErrors, protocolErrors);
    if (responseErrors + protocolErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    int timeoutNs;
    timeoutNs = commandCount * (QUEUE_DEPTH + 3) * 10 + 1000;  // Slack for reset and idles
    #(timeoutNs);
    $display("Timeout at %0d ns: responses stopped arriving, %0d of %0d received",
             $time, responseCount, commandsSent);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== arrayHeap.f ====
verilog/heapPkg.sv
verilog/commandQueue.sv
verilog/heapAllocator.sv
verilog/arrayStore.sv
verilog/arrayHeap.sv
verification/arrayHeapTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the array heap testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arrayHeap.f --top-module arrayHeapTb \
  -o arrayHeapSim &&
  output=$(./obj_dir/arrayHeapSim) &&
  echo "$output" &&
  echo "$output" | grep -qx "PASS: all tests" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
